//--- sal_pkg.sv
package sal_pkg;

    // lane geometry
    localparam int CHANNEL_WIDTH  = 16;
    localparam int SUBFRAME_WIDTH = 8;
    localparam int NUM_SUBFRAMES  = CHANNEL_WIDTH / SUBFRAME_WIDTH;

    // trellis patterns
    localparam int NUM_PATTERNS  = 4;
    localparam int PATTERN_DEPTH = 4;
    localparam int BRANCH_WIDTH  = 2;

    // symbol and error widths, PAM4 levels -3 -1 1 3
    localparam int SYM_WIDTH      = 3;
    localparam int SYM_MAX        = 3;
    localparam int EST_ERR_WIDTH  = 8;
    localparam int ENER_WIDTH     = 8;
    localparam int FLAG_WIDTH     = 4;
    localparam int LANE_IDX_WIDTH = 3;

    // selector stage plus expander stage
    localparam int DATAPATH_LATENCY = 2;

    typedef logic signed [SYM_WIDTH-1:0]     symbol_t;
    typedef logic signed [EST_ERR_WIDTH-1:0] est_err_t;
    typedef logic        [ENER_WIDTH-1:0]    ener_t;
    typedef logic        [FLAG_WIDTH-1:0]    flag_t;
    typedef logic signed [BRANCH_WIDTH-1:0]  branch_t;

    typedef struct packed {
        symbol_t  [CHANNEL_WIDTH-1:0] symbols;
        est_err_t [CHANNEL_WIDTH-1:0] res_errs;
    } lane_word_t;

    typedef struct packed {
        flag_t [CHANNEL_WIDTH-1:0] flags;
        ener_t [CHANNEL_WIDTH-1:0] eners;
    } flag_word_t;

    // winning flag of one subframe
    typedef struct packed {
        logic                      hit;
        logic [LANE_IDX_WIDTH-1:0] lane;
        flag_t                     flag;
    } pick_t;

    // indexed [pattern][offset from flagged lane]
    typedef branch_t [NUM_PATTERNS-1:0][PATTERN_DEPTH-1:0] pattern_table_t;

endpackage

//--- delay_line.sv
`timescale 1ns/1ps

module delay_line
    import sal_pkg::*;
#(
    parameter int DEPTH = 1
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  lane_word_t word_i,
    output lane_word_t word_o
);

    // stage 0 takes the input, last stage drives the output
    lane_word_t [DEPTH-1:0] stages;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stages <= '0;
        end else begin
            stages[0] <= word_i;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign word_o = stages[DEPTH-1];

endmodule

//--- subframe_selector.sv
`timescale 1ns/1ps

module subframe_selector
    import sal_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  flag_word_t                flag_word_i,
    output pick_t [NUM_SUBFRAMES-1:0] picks_o,
    output pick_t [NUM_SUBFRAMES-1:0] prev_picks_o
);

    pick_t [NUM_SUBFRAMES-1:0] picks_d;

    // lowest energy nonzero flag per subframe
    always_comb begin
        ener_t best_ener;
        int    idx;

        for (int s = 0; s < NUM_SUBFRAMES; s++) begin
            picks_d[s] = '0;
            best_ener  = '0;
            for (int l = 0; l < SUBFRAME_WIDTH; l++) begin
                idx = s * SUBFRAME_WIDTH + l;
                // strict compare so the lower lane keeps a tie
                if (flag_word_i.flags[idx] != '0 &&
                    (!picks_d[s].hit || flag_word_i.eners[idx] < best_ener)) begin
                    picks_d[s].hit  = 1'b1;
                    picks_d[s].lane = LANE_IDX_WIDTH'(l);
                    picks_d[s].flag = flag_word_i.flags[idx];
                    best_ener       = flag_word_i.eners[idx];
                end
            end
        end
    end

    // prev picks feed patterns that run past the word end
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            picks_o      <= '0;
            prev_picks_o <= '0;
        end else begin
            picks_o      <= picks_d;
            prev_picks_o <= picks_o;
        end
    end

endmodule

//--- pattern_expander.sv
`timescale 1ns/1ps

module pattern_expander
    import sal_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  pick_t   [NUM_SUBFRAMES-1:0]  picks_i,
    input  pick_t   [NUM_SUBFRAMES-1:0]  prev_picks_i,
    input  pattern_table_t               patterns_i,
    output symbol_t [CHANNEL_WIDTH-1:0]  adjust_o
);

    symbol_t [CHANNEL_WIDTH-1:0] adjust_d;

    // signed pattern entry one pick adds to one lane, start is the subframe's word-global base
    function automatic int lane_contrib(pick_t pk, int start, int lane,
                                        pattern_table_t tbl);
        int      d;
        int      k;
        int      val;
        branch_t br;

        d   = lane - start - int'(pk.lane);
        val = 0;
        if (pk.hit && d >= 0 && d < PATTERN_DEPTH) begin
            if (pk.flag >= 1 && pk.flag <= NUM_PATTERNS) begin
                k   = int'(pk.flag) - 1;
                br  = tbl[k][d];
                val = int'(br);
            end else if (pk.flag > NUM_PATTERNS && pk.flag <= 2 * NUM_PATTERNS) begin
                k   = int'(pk.flag) - NUM_PATTERNS - 1;
                br  = tbl[k][d];
                val = -int'(br);
            end
        end
        return val;
    endfunction

    always_comb begin
        int acc;

        for (int i = 0; i < CHANNEL_WIDTH; i++) begin
            acc = 0;
            for (int s = 0; s < NUM_SUBFRAMES; s++) begin
                acc += lane_contrib(picks_i[s], s * SUBFRAME_WIDTH, i, patterns_i);
                // previous word sits one word to the left
                acc += lane_contrib(prev_picks_i[s], s * SUBFRAME_WIDTH - CHANNEL_WIDTH,
                                    i, patterns_i);
            end
            if (acc > SYM_MAX) begin
                adjust_d[i] = symbol_t'(SYM_MAX);
            end else if (acc < -SYM_MAX) begin
                adjust_d[i] = symbol_t'(-SYM_MAX);
            end else begin
                adjust_d[i] = symbol_t'(acc);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            adjust_o <= '0;
        end else begin
            adjust_o <= adjust_d;
        end
    end

endmodule

//--- symbol_adjust_locator_datapath.sv
`timescale 1ns/1ps

module symbol_adjust_locator_datapath
    import sal_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  lane_word_t                   lane_word_i,
    input  flag_word_t                   flag_word_i,
    input  pattern_table_t               patterns_i,
    output lane_word_t                   lane_word_o,
    output symbol_t [CHANNEL_WIDTH-1:0]  adjust_o
);

    pick_t [NUM_SUBFRAMES-1:0] picks;
    pick_t [NUM_SUBFRAMES-1:0] prev_picks;

    // symbols and residuals wait for the locator path
    delay_line #(
        .DEPTH(DATAPATH_LATENCY)
    ) lane_delay_u (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .word_i (lane_word_i),
        .word_o (lane_word_o)
    );

    // locator, first stage
    subframe_selector selector_u (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flag_word_i (flag_word_i),
        .picks_o     (picks),
        .prev_picks_o(prev_picks)
    );

    // locator, second stage
    pattern_expander expander_u (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .picks_i     (picks),
        .prev_picks_i(prev_picks),
        .patterns_i  (patterns_i),
        .adjust_o    (adjust_o)
    );

endmodule

//--- symbol_corrector.sv
`timescale 1ns/1ps

module symbol_corrector
    import sal_pkg::*;
(
    input  symbol_t [CHANNEL_WIDTH-1:0] symbols_i,
    input  symbol_t [CHANNEL_WIDTH-1:0] adjust_i,
    output symbol_t [CHANNEL_WIDTH-1:0] corrected_o
);

    always_comb begin
        // one guard bit holds any sum of two symbols
        logic signed [SYM_WIDTH:0] sum;

        for (int i = 0; i < CHANNEL_WIDTH; i++) begin
            sum = (SYM_WIDTH + 1)'(symbols_i[i]) + (SYM_WIDTH + 1)'(adjust_i[i]);
            if (sum > SYM_MAX) begin
                corrected_o[i] = symbol_t'(SYM_MAX);
            end else if (sum < -SYM_MAX) begin
                corrected_o[i] = symbol_t'(-SYM_MAX);
            end else begin
                corrected_o[i] = symbol_t'(sum);
            end
        end
    end

endmodule

//--- sal_top.sv
`timescale 1ns/1ps

module sal_top
    import sal_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  lane_word_t                   lane_word_i,
    input  flag_word_t                   flag_word_i,
    input  pattern_table_t               patterns_i,
    output lane_word_t                   lane_word_o,
    output symbol_t [CHANNEL_WIDTH-1:0]  adjust_o,
    output symbol_t [CHANNEL_WIDTH-1:0]  corrected_o
);

    symbol_adjust_locator_datapath datapath_u (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .lane_word_i(lane_word_i),
        .flag_word_i(flag_word_i),
        .patterns_i (patterns_i),
        .lane_word_o(lane_word_o),
        .adjust_o   (adjust_o)
    );

    // aligned symbols plus their adjustments
    symbol_corrector corrector_u (
        .symbols_i  (lane_word_o.symbols),
        .adjust_i   (adjust_o),
        .corrected_o(corrected_o)
    );

endmodule

//--- sal_assertions.sv
`timescale 1ns/1ps

module sal_assertions
    import sal_pkg::*;
(
    input logic                        clk,
    input logic                        rst_n_i,
    input flag_word_t                  flag_word_i,
    input lane_word_t                  lane_word_o,
    input symbol_t [CHANNEL_WIDTH-1:0] adjust_o,
    input symbol_t [CHANNEL_WIDTH-1:0] corrected_o
);

    function automatic logic all_in_range(symbol_t [CHANNEL_WIDTH-1:0] v);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < CHANNEL_WIDTH; i++) begin
            if (v[i] > SYM_MAX || v[i] < -SYM_MAX) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // registers clear on the edge that samples reset
    reset_clears_outputs: assert property (@(posedge clk)
        !rst_n_i |=> (lane_word_o == '0 && adjust_o == '0 && corrected_o == '0))
        else $error("outputs not zero after a reset edge");

    corrected_saturated: assert property (@(posedge clk) disable iff (!rst_n_i)
        all_in_range(corrected_o))
        else $error("corrected_o outside the symbol range");

    // no flags in this word or the one before means no adjustment
    quiet_words_no_adjust: assert property (@(posedge clk) disable iff (!rst_n_i)
        (flag_word_i.flags == '0 && $past(flag_word_i.flags) == '0) |-> ##2 adjust_o == '0)
        else $error("adjust_o nonzero after two flag-free words");

endmodule

bind sal_top sal_assertions assertions_u (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .flag_word_i(flag_word_i),
    .lane_word_o(lane_word_o),
    .adjust_o   (adjust_o),
    .corrected_o(corrected_o)
);

//--- tb_sal.sv
`timescale 1ns/1ps

module tb_sal
    import sal_pkg::*;
();

    localparam int NUM_WORDS = 3000;

    typedef struct {
        lane_word_t lw;
        flag_word_t fw;
        int         due;
    } word_entry_t;

    logic                        clk;
    logic                        rst_n_i;
    lane_word_t                  lane_word_i;
    flag_word_t                  flag_word_i;
    pattern_table_t              patterns_i;
    lane_word_t                  lane_word_o;
    symbol_t [CHANNEL_WIDTH-1:0] adjust_o;
    symbol_t [CHANNEL_WIDTH-1:0] corrected_o;

    logic [31:0] lfsr;
    int          pat_val [NUM_PATTERNS][PATTERN_DEPTH];
    word_entry_t applied_q[$];
    flag_word_t  prev_fw;
    int          cycle;

    sal_top DUT (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .lane_word_i(lane_word_i),
        .flag_word_i(flag_word_i),
        .patterns_i (patterns_i),
        .lane_word_o(lane_word_o),
        .adjust_o   (adjust_o),
        .corrected_o(corrected_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int unsigned v);
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | 32'(lfsr[0]);
        end
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("ERROR at %0t: %s = %0d, expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic load_patterns();
        int unsigned v;
        for (int k = 0; k < NUM_PATTERNS; k++) begin
            for (int d = 0; d < PATTERN_DEPTH; d++) begin
                take_bits(BRANCH_WIDTH, v);
                patterns_i[k][d] = branch_t'(v);
                pat_val[k][d]    = (v >= 2) ? int'(v) - 4 : int'(v);
            end
        end
    endtask

    // narrow energies make ties likely
    task automatic make_word(input bit narrow_ener, output lane_word_t lw,
                             output flag_word_t fw);
        int unsigned v;
        lw = '0;
        fw = '0;
        for (int i = 0; i < CHANNEL_WIDTH; i++) begin
            take_bits(SYM_WIDTH, v);
            lw.symbols[i] = symbol_t'(v);
            take_bits(EST_ERR_WIDTH, v);
            lw.res_errs[i] = est_err_t'(v);
            take_bits(6, v);
            if (v < 11) begin
                take_bits(3, v);
                fw.flags[i] = flag_t'(v + 1);
            end
            take_bits(narrow_ener ? 2 : ENER_WIDTH, v);
            fw.eners[i] = ener_t'(v);
        end
    endtask

    // minimum energy first, then the first lane holding it
    function automatic int winner_lane(flag_word_t fw, int s);
        int best;
        int idx;
        best = 1 << 30;
        for (int l = 0; l < SUBFRAME_WIDTH; l++) begin
            idx = s * SUBFRAME_WIDTH + l;
            if (fw.flags[idx] != 0 && int'(fw.eners[idx]) < best) begin
                best = int'(fw.eners[idx]);
            end
        end
        for (int l = 0; l < SUBFRAME_WIDTH; l++) begin
            idx = s * SUBFRAME_WIDTH + l;
            if (fw.flags[idx] != 0 && int'(fw.eners[idx]) == best) begin
                return l;
            end
        end
        return -1;
    endfunction

    function automatic int spread(flag_word_t fw, int base, int lane);
        int total;
        int w;
        int f;
        int d;
        total = 0;
        for (int s = 0; s < NUM_SUBFRAMES; s++) begin
            w = winner_lane(fw, s);
            if (w >= 0) begin
                f = int'(fw.flags[s * SUBFRAME_WIDTH + w]);
                d = lane - (base + s * SUBFRAME_WIDTH + w);
                if (d >= 0 && d < PATTERN_DEPTH) begin
                    if (f <= NUM_PATTERNS) begin
                        total += pat_val[f - 1][d];
                    end else begin
                        total -= pat_val[f - NUM_PATTERNS - 1][d];
                    end
                end
            end
        end
        return total;
    endfunction

    function automatic int clip_sym(int v);
        return (v > SYM_MAX) ? SYM_MAX : ((v < -SYM_MAX) ? -SYM_MAX : v);
    endfunction

    task automatic check_word(input word_entry_t e, input flag_word_t prev);
        int adj;
        for (int i = 0; i < CHANNEL_WIDTH; i++) begin
            adj = clip_sym(spread(e.fw, 0, i) + spread(prev, -CHANNEL_WIDTH, i));
            check_value($sformatf("lane_word_o.symbols[%0d]", i),
                        int'(lane_word_o.symbols[i]), int'(e.lw.symbols[i]));
            check_value($sformatf("lane_word_o.res_errs[%0d]", i),
                        int'(lane_word_o.res_errs[i]), int'(e.lw.res_errs[i]));
            check_value($sformatf("adjust_o[%0d]", i), int'(adjust_o[i]), adj);
            check_value($sformatf("corrected_o[%0d]", i), int'(corrected_o[i]),
                        clip_sym(int'(e.lw.symbols[i]) + adj));
        end
    endtask

    task automatic check_due();
        if (applied_q.size() > 0 && applied_q[0].due == cycle) begin
            check_word(applied_q[0], prev_fw);
            prev_fw = applied_q[0].fw;
            void'(applied_q.pop_front());
        end
    endtask

    initial begin
        word_entry_t e;
        int          guard;
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        lane_word_i = '0;
        flag_word_i = '0;
        patterns_i  = '0;
        lfsr        = 32'h31e;
        prev_fw     = '0;
        cycle       = 0;
        load_patterns();

        // reset held for two edges, released on the second
        guard = 0;
        while (guard < 2) begin
            @(posedge clk);
            guard++;
            if (guard == 2) begin
                rst_n_i <= 1'b1;
            end
        end
        @(negedge clk);
        e.lw  = '0;
        e.fw  = '0;
        e.due = 0;
        check_word(e, '0);

        for (int n = 0; n < NUM_WORDS; n++) begin
            @(posedge clk);
            cycle++;
            make_word((n % 4) == 3, e.lw, e.fw);
            e.due = cycle + DATAPATH_LATENCY;
            lane_word_i <= e.lw;
            flag_word_i <= e.fw;
            applied_q.push_back(e);
            @(negedge clk);
            check_due();
        end

        guard = 0;
        while (applied_q.size() > 0) begin
            @(posedge clk);
            cycle++;
            lane_word_i <= '0;
            flag_word_i <= '0;
            @(negedge clk);
            check_due();
            guard++;
            if (guard > 10) begin
                report_failure("timeout: applied words never came out of the DUT");
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- build.f
sal_pkg.sv
delay_line.sv
subframe_selector.sv
pattern_expander.sv
symbol_adjust_locator_datapath.sv
symbol_corrector.sv
sal_top.sv
sal_assertions.sv
tb_sal.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench, pass only when the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sal -f build.f

out=$(./obj_dir/Vtb_sal)
echo "$out"

echo "$out" | grep -qx "Finished with no errors"
echo "simulation passed"
